/* tb.f */
enc_pkg.sv
enc_ctrl.sv
enc_buffer.sv
enc_parity.sv
enc_sink.sv
enc_top.sv
enc_props.sv
tb_enc.sv

/* Makefile */
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_enc: tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module tb_enc -Mdir obj_dir -f tb.f

run: obj_dir/Vtb_enc
	@out="$$(./obj_dir/Vtb_enc)"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

/* tb_enc.sv */
// Encoder subsystem testbench
`timescale 1ns/100ps

module tb_enc
  import enc_pkg::*;
();

  // Blocks per randomized test
  localparam int RAND_BLKS = 30;
  // Upper bound on output words over all tests, fixed blocks first
  localparam int MAX_WORDS = 41 + 2 * RAND_BLKS * (2**ADDR_W);
  localparam int LIMIT_CYC = MAX_WORDS * 40 + 1000;

  logic      iclk;
  logic      ireset;
  logic      in_valid;
  in_beat_t  in_beat;
  logic      in_ready;
  logic      out_req;
  logic      out_valid;
  out_beat_t out_beat;

  // Words the DUT still owes, oldest first
  out_beat_t   exp_q [$];
  int          errors;
  int          checks;
  int          test_num;
  int          test_err0;
  int          test_chk0;
  // Chance of a read request in a cycle, in percent
  int unsigned req_pct;

  enc_top dut0 (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_req   (out_req),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  // ********************************************************************
  // Reference model
  // ********************************************************************

  // XOR of every data word rotated left by its index mod DAT_W
  function automatic logic [DAT_W-1:0] enc_ref_parity(input logic [DAT_W-1:0] d [16],
                                                      input int n);
    logic [DAT_W-1:0] acc;
    logic [DAT_W-1:0] rot;
    int               sh;
    acc = '0;
    for (int i = 0; i < n; i++) begin
      sh = i % DAT_W;
      // Bit b moves up by sh places and wraps round the top
      for (int b = 0; b < DAT_W; b++) begin
        rot[(b + sh) % DAT_W] = d[i][b];
      end
      acc = acc ^ rot;
    end
    return acc;
  endfunction

  // ********************************************************************
  // Checks
  // ********************************************************************

  task automatic check_beat(input string name, input out_beat_t got, input out_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Every valid output word is matched against the head of the queue
  always @(negedge iclk) begin
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output word %h arrived while no word was expected", out_beat);
      end else begin
        check_beat("out_beat", out_beat, exp_q.pop_front());
      end
    end
  end

  // ********************************************************************
  // Stimulus
  // ********************************************************************

  // Read requests are redrawn every cycle
  initial begin
    forever begin
      @(posedge iclk);
      #1;
      out_req = ($urandom_range(99, 0) < req_pct);
    end
  end

  // Sends one block and queues its expected output words
  // Entered and left 1 ns after a rising edge
  task automatic send_block(input int n, input int gap_max);
    logic [DAT_W-1:0] d [16];
    logic [TAG_W-1:0] tag;
    logic [TAG_W-1:0] t;
    int unsigned      r;
    int               gap;
    logic             acc;
    out_beat_t        exp;
    r   = $urandom;
    tag = r[TAG_W-1:0];
    for (int i = 0; i < n; i++) begin
      r    = $urandom;
      d[i] = r[DAT_W-1:0];
      exp  = '{sop: (i == 0), eop: 1'b0, dat: d[i], tag: tag};
      exp_q.push_back(exp);
    end
    // Parity closes the block and carries the same tag
    exp = '{sop: 1'b0, eop: 1'b1, dat: enc_ref_parity(d, n), tag: tag};
    exp_q.push_back(exp);
    for (int i = 0; i < n; i++) begin
      gap = (gap_max > 0) ? int'($urandom_range(gap_max, 0)) : 0;
      if (gap > 0) begin
        in_valid = 1'b0;
        repeat (gap) @(posedge iclk);
        #1;
      end
      // Tags after the first word are noise the DUT has to ignore
      r        = $urandom;
      t        = (i == 0) ? tag : r[TAG_W-1:0];
      in_valid = 1'b1;
      in_beat  = '{dat: d[i], last: (i == n - 1), tag: t};
      // in_ready depends on the FSM state only, so it is settled here
      do begin
        acc = in_ready;
        @(posedge iclk);
        #1;
      end while (!acc);
    end
    in_valid = 1'b0;
    // Input must be shut off once the block is complete
    check_bit("in_ready", in_ready, 1'b0);
  endtask

  task automatic start_test();
    test_num++;
    test_err0 = errors;
    test_chk0 = checks;
  endtask

  // Waits for the queue to drain, then a few cycles for stray words
  task automatic end_test(input string name);
    while (exp_q.size() != 0) begin
      @(posedge iclk);
      #1;
    end
    repeat (8) @(posedge iclk);
    #1;
    $display("Test %0d %s: %0d checks, %0d errors", test_num, name,
             checks - test_chk0, errors - test_err0);
  endtask

  // ********************************************************************
  // Test sequence
  // ********************************************************************

  initial begin
    int n;
    void'($urandom(94));
    errors   = 0;
    checks   = 0;
    test_num = 0;
    req_pct  = 100;
    ireset   = 1'b1;
    in_valid = 1'b0;
    in_beat  = '0;
    out_req  = 1'b0;

    // Output and input stay closed through reset, input opens right after it
    start_test();
    repeat (4) begin
      @(posedge iclk);
      #1;
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("in_ready", in_ready, 1'b0);
    end
    ireset = 1'b0;
    @(posedge iclk);
    #1;
    check_bit("in_ready", in_ready, 1'b1);
    end_test("reset");

    // Shortest and longest blocks back to back with a free-running reader
    start_test();
    for (int k = 0; k < 5; k++) begin
      send_block(((k % 2) == 0) ? 2 : 15, 0);
    end
    end_test("lengths 2 and 15 back to back");

    start_test();
    req_pct = 60;
    for (int k = 0; k < RAND_BLKS; k++) begin
      n = int'($urandom_range(15, 2));
      send_block(n, 3);
    end
    end_test("random lengths with input gaps");

    // Slow reader holds the input off for long stretches
    start_test();
    req_pct = 20;
    for (int k = 0; k < RAND_BLKS; k++) begin
      n = int'($urandom_range(15, 2));
      send_block(n, 0);
    end
    end_test("sparse read requests");

    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Bound from the word count of all tests
  initial begin
    repeat (LIMIT_CYC) @(posedge iclk);
    $display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYC);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* enc_props.sv */
// Encoder protocol assertions
`timescale 1ns/100ps

module enc_props
  import enc_pkg::*;
(
  input logic     iclk,
  input logic     ireset,
  input logic     in_valid,
  input in_beat_t in_beat,
  input logic     in_ready,
  input logic     out_req,
  input logic     out_valid,
  input logic     blk_full,
  input logic     blk_release
);

  logic blk_full_q;
  logic reading;

  // The sink reads from the second cycle of blk_full up to the release
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      blk_full_q <= 1'b0;
    end else begin
      blk_full_q <= blk_full;
    end
  end

  assign reading = blk_full & blk_full_q;

  // ********************************************************************
  // Properties
  // ********************************************************************

  // A word that waits must stay offered and unchanged
  a_in_hold : assert property (@(posedge iclk) disable iff (ireset)
    in_valid && !in_ready |=> in_valid && $stable(in_beat))
    else $error("in_beat changed or was withdrawn before acceptance");

  // One valid word for each request, 3 cycles on
  a_out_follow : assert property (@(posedge iclk) disable iff (ireset)
    out_valid == $past(reading && out_req, 3))
    else $error("out_valid does not follow out_req by 3 cycles");

  // Input closes after the last word and opens only after the release
  a_ready_last : assert property (@(posedge iclk) disable iff (ireset)
    in_valid && in_ready && in_beat.last |=> !in_ready)
    else $error("in_ready high right after the last word");

  a_ready_hold : assert property (@(posedge iclk) disable iff (ireset)
    !in_ready && !blk_release |=> !in_ready)
    else $error("in_ready rose without a release");

  a_reset_quiet : assert property (@(posedge iclk)
    ireset && $past(ireset) |-> !in_ready && !out_valid && !blk_full && !blk_release)
    else $error("input, output or handoff active during reset");

endmodule

bind enc_top enc_props props0 (
  .iclk        (iclk),
  .ireset      (ireset),
  .in_valid    (in_valid),
  .in_beat     (in_beat),
  .in_ready    (in_ready),
  .out_req     (out_req),
  .out_valid   (out_valid),
  .blk_full    (blk_full),
  .blk_release (blk_release)
);

/* enc_top.sv */
// Block encoder output subsystem
`timescale 1ns/100ps

module enc_top
  import enc_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  // Input stream
  input  logic      in_valid,
  input  in_beat_t  in_beat,
  output logic      in_ready,
  // Output stream, request driven
  input  logic      out_req,
  output logic      out_valid,
  output out_beat_t out_beat
);

  // ********************************************************************
  // Internal wiring
  // ********************************************************************

  // Buffer write side
  logic             wr_en;
  addr_t            wr_addr;
  logic [DAT_W-1:0] wr_dat;
  // Parity accumulator
  logic             par_clr;
  logic             par_step;
  addr_t            par_idx;
  logic [DAT_W-1:0] par_word;
  // Block handoff
  logic             blk_full;
  addr_t            blk_num;
  logic [TAG_W-1:0] blk_tag;
  logic             blk_release;
  // Buffer read side
  addr_t            rd_addr;
  logic [DAT_W-1:0] rd_dat;

  // ********************************************************************
  // Write side
  // ********************************************************************

  enc_ctrl u_ctrl (
    .iclk        (iclk),
    .ireset      (ireset),
    .in_valid    (in_valid),
    .in_beat     (in_beat),
    .in_ready    (in_ready),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_dat      (wr_dat),
    .par_clr     (par_clr),
    .par_step    (par_step),
    .par_idx     (par_idx),
    .par_word    (par_word),
    .blk_full    (blk_full),
    .blk_num     (blk_num),
    .blk_tag     (blk_tag),
    .blk_release (blk_release)
  );

  // Accumulates straight from the input data word
  enc_parity u_parity (
    .iclk   (iclk),
    .ireset (ireset),
    .clr    (par_clr),
    .step   (par_step),
    .idx    (par_idx),
    .dat    (in_beat.dat),
    .parity (par_word)
  );

  enc_buffer u_buffer (
    .iclk    (iclk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_dat  (wr_dat),
    .rd_dat  (rd_dat)
  );

  // ********************************************************************
  // Read side
  // ********************************************************************

  enc_sink u_sink (
    .iclk        (iclk),
    .ireset      (ireset),
    .num         (blk_num),
    .full        (blk_full),
    .rdat        (rd_dat),
    .tag         (blk_tag),
    .blk_release (blk_release),
    .raddr       (rd_addr),
    .req         (out_req),
    .out_valid   (out_valid),
    .out_beat    (out_beat)
  );

endmodule

/* enc_sink.sv */
// Encoder buffer readout
`timescale 1ns/100ps

module enc_sink
  import enc_pkg::*;
(
  input  logic             iclk,
  input  logic             ireset,
  // Data word count of the block, parity sits at this address
  input  addr_t            num,
  // Buffer side
  input  logic             full,
  input  logic [DAT_W-1:0] rdat,
  input  logic [TAG_W-1:0] tag,
  output logic             blk_release,
  output addr_t            raddr,
  // Output side
  input  logic             req,
  output logic             out_valid,
  output out_beat_t        out_beat
);

  typedef enum logic {
    ST_IDLE,
    ST_READ
  } state_t;

  // Read address counter with a look-ahead flag for the final address
  typedef struct packed {
    addr_t done_value;
    logic  done;
    addr_t value;
  } cnt_t;

  state_t           state;
  cnt_t             cnt;
  logic             start;
  logic             rd_step;
  // Delay lines matching the buffer read latency plus the output register
  logic [2:0]       val_sr;
  logic [2:0]       eop_sr;
  logic [1:0]       sop_sr;
  logic             sop;
  logic [DAT_W-1:0] dat_q;
  logic [TAG_W-1:0] tag_q;

  // ********************************************************************
  // FSM
  // ********************************************************************

  assign start       = (state == ST_IDLE) & full;
  assign rd_step     = (state == ST_READ) & req;
  // Buffer is handed back as soon as the final word is requested
  assign blk_release = rd_step & cnt.done;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE : state <= full        ? ST_READ : ST_IDLE;
        ST_READ : state <= blk_release ? ST_IDLE : ST_READ;
        default : state <= ST_IDLE;
      endcase
    end
  end

  // ********************************************************************
  // Address counter
  // ********************************************************************

  // done rises one step ahead of the last address, hence the 2 word minimum
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt <= '0;
    end else if (state == ST_IDLE) begin
      cnt.value      <= '0;
      cnt.done       <= 1'b0;
      cnt.done_value <= num - 1'b1;
    end else if (rd_step) begin
      cnt.value <= cnt.done ? '0 : (cnt.value + 1'b1);
      cnt.done  <= (cnt.value == cnt.done_value);
    end
  end

  assign raddr = cnt.value;

  // ********************************************************************
  // Output framing
  // ********************************************************************

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_sr <= '0;
      eop_sr <= '0;
      sop_sr <= '0;
      sop    <= 1'b0;
    end else begin
      // Each request becomes one valid word 3 cycles on
      val_sr <= {val_sr[1:0], rd_step};
      // eop rides along with the request for the parity word
      eop_sr <= {eop_sr[1:0], blk_release};
      sop_sr <= {sop_sr[0], start};
      // sop is armed early and dropped after the first valid word
      if (sop_sr[1]) begin
        sop <= 1'b1;
      end else if (out_valid) begin
        sop <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge iclk) begin
    dat_q <= rdat;
    if (start) begin
      tag_q <= tag;
    end
  end

  assign out_valid = val_sr[2];
  assign out_beat  = '{sop: sop, eop: eop_sr[2], dat: dat_q, tag: tag_q};

endmodule

/* enc_parity.sv */
// Rotating XOR parity accumulator
`timescale 1ns/100ps

module enc_parity
  import enc_pkg::*;
(
  input  logic             iclk,
  input  logic             ireset,
  input  logic             clr,
  input  logic             step,
  input  addr_t            idx,
  input  logic [DAT_W-1:0] dat,
  output logic [DAT_W-1:0] parity
);

  // Rotation amount width, DAT_W is a power of two
  localparam int SH_W = $clog2(DAT_W);

  logic [SH_W-1:0]    sh;
  logic [2*DAT_W-1:0] dbl;
  logic [DAT_W-1:0]   rot;

  // ********************************************************************
  // Rotate left by idx mod DAT_W
  // ********************************************************************

  // Low bits of the index give the modulo directly
  assign sh  = idx[SH_W-1:0];

  // Upper half of the doubled word shifted left is the rotated word
  assign dbl = {dat, dat} << sh;
  assign rot = dbl[2*DAT_W-1 -: DAT_W];

  // ********************************************************************
  // Accumulator
  // ********************************************************************

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      parity <= '0;
    end else if (clr) begin
      // Fresh start for the next block
      parity <= '0;
    end else if (step) begin
      parity <= parity ^ rot;
    end
  end

endmodule

/* enc_buffer.sv */
// Encoder block memory
`timescale 1ns/100ps

module enc_buffer
  import enc_pkg::*;
(
  input  logic             iclk,
  // Write port
  input  logic             wr_en,
  input  addr_t            wr_addr,
  // Read port
  input  addr_t            rd_addr,
  input  logic [DAT_W-1:0] wr_dat,
  output logic [DAT_W-1:0] rd_dat
);

  // One block of data words plus its parity word
  logic [DAT_W-1:0] mem [2**ADDR_W];

  // Registered read address
  addr_t rd_addr_q;

  // ********************************************************************
  // Write side
  // ********************************************************************

  always_ff @(posedge iclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_dat;
    end
  end

  // ********************************************************************
  // Read side
  // ********************************************************************

  // Address register then output register, so data lands 2 cycles later
  // Readout never overlaps a write to the same block
  always_ff @(posedge iclk) begin
    rd_addr_q <= rd_addr;
    rd_dat    <= mem[rd_addr_q];
  end

endmodule

/* enc_ctrl.sv */
// Encoder write-side control
`timescale 1ns/100ps

module enc_ctrl
  import enc_pkg::*;
(
  input  logic             iclk,
  input  logic             ireset,
  // Input stream
  input  logic             in_valid,
  input  in_beat_t         in_beat,
  output logic             in_ready,
  // Buffer write port
  output logic             wr_en,
  output addr_t            wr_addr,
  output logic [DAT_W-1:0] wr_dat,
  // Parity accumulator
  output logic             par_clr,
  output logic             par_step,
  output addr_t            par_idx,
  input  logic [DAT_W-1:0] par_word,
  // Handoff to the sink
  output logic             blk_full,
  output addr_t            blk_num,
  output logic [TAG_W-1:0] blk_tag,
  input  logic             blk_release
);

  typedef enum logic [1:0] {
    ST_COLLECT,
    ST_WR_PAR,
    ST_WAIT
  } state_t;

  state_t state;
  // Number of words written so far, doubles as the next write address
  addr_t  cnt;
  logic   accept;

  // ********************************************************************
  // Input handshake
  // ********************************************************************

  // Input is only taken while the block is still being collected and out of reset
  assign in_ready = (state == ST_COLLECT) & ~ireset;
  assign accept   = in_valid & in_ready;

  // ********************************************************************
  // FSM
  // ********************************************************************

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= ST_COLLECT;
      cnt     <= '0;
      blk_num <= '0;
    end else begin
      case (state)
        ST_COLLECT : begin
          if (accept) begin
            cnt <= cnt + 1'b1;
            // After the last data word cnt already points at the parity slot
            if (in_beat.last) begin
              state <= ST_WR_PAR;
            end
          end
        end
        ST_WR_PAR : begin
          // Parity goes behind the data, cnt equals the data word count here
          blk_num <= cnt;
          state   <= ST_WAIT;
        end
        ST_WAIT : begin
          // The sink frees the buffer when it asks for the final word
          if (blk_release) begin
            cnt   <= '0;
            state <= ST_COLLECT;
          end
        end
        default : begin
          state <= ST_COLLECT;
        end
      endcase
    end
  end

  // The tag comes with the first word of the block
  always_ff @(posedge iclk) begin
    if (accept && (cnt == '0)) begin
      blk_tag <= in_beat.tag;
    end
  end

  // ********************************************************************
  // Buffer and parity control
  // ********************************************************************

  // Data words while collecting, then one parity word
  assign wr_en    = accept | (state == ST_WR_PAR);
  assign wr_addr  = cnt;
  assign wr_dat   = (state == ST_WR_PAR) ? par_word : in_beat.dat;

  // Word index sets the rotation of each data word
  assign par_step = accept;
  assign par_idx  = cnt;
  assign par_clr  = (state == ST_WAIT) & blk_release;

  // Block stays offered to the sink for the whole wait
  assign blk_full = (state == ST_WAIT);

endmodule

/* enc_pkg.sv */
// Encoder shared definitions
package enc_pkg;

  // ********************************************************************
  // Widths
  // ********************************************************************

  // Data and parity word width
  localparam int DAT_W  = 8;
  // Buffer address width, one block of up to 16 words
  localparam int ADDR_W = 4;
  // Block tag width
  localparam int TAG_W  = 4;

  // Buffer address, also used as a word count
  typedef logic [ADDR_W-1:0] addr_t;

  // ********************************************************************
  // Stream beats
  // ********************************************************************

  // One input word; the tag only matters on the first word of a block
  typedef struct packed {
    logic [DAT_W-1:0] dat;
    logic             last;
    logic [TAG_W-1:0] tag;
  } in_beat_t;

  // One output word
  // The tag is repeated on every word of the block
  typedef struct packed {
    logic             sop;
    logic             eop;
    logic [DAT_W-1:0] dat;
    logic [TAG_W-1:0] tag;
  } out_beat_t;

endpackage
